/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbDatapath
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

/* all.f */
verilog/datapathPkg.sv
verilog/regBank.sv
verilog/memIoRegs.sv
verilog/busMux.sv
verilog/aluUnit.sv
verilog/datapath.sv
dv/tbDatapath.sv

/* dv/tbDatapath.sv */
`timescale 1ns/10ps

module tbDatapath;

    typedef struct packed {
        datapathPkg::loadStrbT  load;
        datapathPkg::driveStrbT drive;
        logic                   mdrIn, read, inPortIn, incPc;
        datapathPkg::aluOpT     opcode;
        datapathPkg::wordT      memData, inPort, constData;
        datapathPkg::wordT      expBus;
        logic                   chkBus;
        datapathPkg::wordT      expAddr;
        logic                   chkAddr;
    } stepT;  // one microstep

    // strobe bit positions from the lsb of each struct
    localparam int NoLd = -1, LdZ = 0, LdY = 1, LdMar = 2, LdPc = 3, LdLo = 4, LdHi = 5,
                   LdR0 = 6;
    localparam int NoDr = -1, DrC = 0, DrIn = 1, DrMdr = 2, DrPc = 3, DrZLo = 4, DrZHi = 5,
                   DrLo = 6, DrHi = 7, DrR0 = 8;
    // {mdrIn, read, inPortIn, incPc}
    localparam logic [3:0] MemRd = 4'b1100, BusMdr = 4'b1000, PortLd = 4'b0010, PcInc = 4'b0001;

    logic                   clk, rstN, mdrIn, read, inPortIn, incPc;
    datapathPkg::loadStrbT  load;
    datapathPkg::driveStrbT drive;
    datapathPkg::aluOpT     opcode;
    datapathPkg::wordT      memData, inPort, constData, busOut, addrOut;

    stepT               steps[$];
    datapathPkg::aluOpT rowOp;
    datapathPkg::wordT  marModel;
    datapathPkg::wordT  pcModel;
    integer             seed;
    int                 errors;
    bit                 tableReady;

    datapath UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic datapathPkg::dwordT aluRef(input datapathPkg::aluOpT op,
            input datapathPkg::wordT a, input datapathPkg::wordT b);
        longint      sa;
        longint      sb;
        logic [63:0] dbl;
        int          n;
        sa  = $signed(a);
        sb  = $signed(b);
        dbl = {a, a};  // rotates fall out of the doubled word
        n   = int'(b[4:0]);
        case (op)
            datapathPkg::OpAdd:  return {32'd0, a + b};
            datapathPkg::OpSub:  return {32'd0, a - b};
            datapathPkg::OpAnd:  return {32'd0, a & b};
            datapathPkg::OpOr:   return {32'd0, a | b};
            datapathPkg::OpShr:  return {32'd0, a >> n};
            datapathPkg::OpShra: return {32'd0, 32'(sa >>> n)};
            datapathPkg::OpShl:  return {32'd0, a << n};
            datapathPkg::OpRor:  return {32'd0, 32'(dbl >> n)};
            datapathPkg::OpRol:  return {32'd0, 32'((dbl << n) >> 32)};
            datapathPkg::OpMul:  return sa * sb;
            datapathPkg::OpDiv:  return (b == 0) ? 64'd0 : {32'(sa % sb), 32'(sa / sb)};
            datapathPkg::OpNeg:  return {32'd0, -b};
            datapathPkg::OpNot:  return {32'd0, ~b};
            default:             return 64'd0;
        endcase
    endfunction

    task automatic row(input int ldPos, input int drPos, input logic [3:0] ctl,
                       input datapathPkg::wordT dat, input datapathPkg::wordT eb);
        stepT s;
        s = '0;
        if (ldPos >= 0) s.load[ldPos] = 1'b1;
        if (drPos >= 0) s.drive[drPos] = 1'b1;
        {s.mdrIn, s.read, s.inPortIn, s.incPc} = ctl;
        s.opcode    = rowOp;
        // decoy words on the sources not in use
        s.memData   = (ctl == MemRd) ? dat : ~dat;
        s.inPort    = (ctl == PortLd) ? dat : dat ^ 32'h5a5a_5a5a;
        s.constData = (drPos == DrC) ? dat : dat + 32'h0101_0101;
        s.expBus    = eb;
        s.chkBus    = 1'b1;
        s.expAddr   = marModel;
        s.chkAddr   = 1'b1;
        steps.push_back(s);
        if (ldPos == LdMar) marModel = eb;  // seen from the next row on
    endtask

    task automatic aluSteps(input datapathPkg::aluOpT op, input datapathPkg::wordT a,
                            input datapathPkg::wordT b);
        datapathPkg::dwordT res;
        res = aluRef(op, a, b);
        row(LdY, DrC, 4'b0, a, a);
        rowOp = op;
        row(LdZ, DrC, 4'b0, b, b);
        rowOp = datapathPkg::OpAdd;
        row(NoLd, DrZLo, 4'b0, 32'd0, res[31:0]);
        row(NoLd, DrZHi, 4'b0, 32'd0, res[63:32]);
    endtask

    task automatic checkWord(input int idx, input datapathPkg::wordT exp,
                             input datapathPkg::wordT act);
        if (act !== exp) begin
            errors++;
            $display("FAIL busOut row %0d: expected %h, got %h", idx, exp, act);
        end
    endtask

    task automatic checkAddr(input int idx, input datapathPkg::wordT exp,
                             input datapathPkg::wordT act);
        if (act !== exp) begin
            errors++;
            $display("FAIL addrOut row %0d: expected %h, got %h", idx, exp, act);
        end
    endtask

    initial begin
        wait (tableReady);
        #((steps.size() + 8) * 10 + 100);  // rows plus reset plus margin
        $display("Timeout: the stimulus table did not finish in the expected time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        datapathPkg::wordT  va;
        datapathPkg::wordT  vb;
        datapathPkg::dwordT res;
        seed     = 32'ha17f_c9ad;
        errors   = 0;
        rowOp    = datapathPkg::OpAdd;
        marModel = '0;
        pcModel  = '0;
        {rstN, mdrIn, read, inPortIn, incPc} = '0;
        load      = '0;
        drive     = '0;
        opcode    = datapathPkg::OpAdd;
        memData   = '0;
        inPort    = '0;
        constData = '0;

        for (int i = 0; i < 24; i++) row(NoLd, i, 4'b0, 32'd0, 32'd0);  // all zero after reset

        row(NoLd, NoDr, MemRd, 32'hcafe_0123, 32'd0);
        row(LdR0 + 3, DrMdr, 4'b0, 32'd0, 32'hcafe_0123);
        row(LdMar, DrR0 + 3, 4'b0, 32'd0, 32'hcafe_0123);
        row(NoLd, NoDr, 4'b0, 32'd0, 32'd0);  // idle bus

        row(NoLd, NoDr, PortLd, 32'h0bad_f00d, 32'd0);
        row(LdR0 + 15, DrIn, 4'b0, 32'd0, 32'h0bad_f00d);
        row(NoLd, DrR0 + 15, 4'b0, 32'd0, 32'h0bad_f00d);
        row(LdR0 + 15, DrC, 4'b0, 32'h1234_5678, 32'h1234_5678);
        row(NoLd, DrR0 + 15, 4'b0, 32'd0, 32'h1234_5678);
        row(NoLd, DrR0 + 15, BusMdr, 32'd0, 32'h1234_5678);  // mdr from the bus
        row(NoLd, DrMdr, 4'b0, 32'd0, 32'h1234_5678);

        for (int op = 0; op < 13; op++) begin
            aluSteps(datapathPkg::aluOpT'(op), 32'hf0f0_1234, 32'h0000_0007);
        end
        aluSteps(datapathPkg::OpMul, 32'hffff_fffd, 32'h7fff_0001);
        aluSteps(datapathPkg::OpDiv, 32'hffff_ff9c, 32'h0000_0007);  // -100 / 7
        aluSteps(datapathPkg::OpDiv, 32'h1234_5678, 32'h0000_0000);
        aluSteps(datapathPkg::OpShra, 32'h8000_0010, 32'h0000_0024);
        for (int op = 0; op < 13; op++) begin
            va = $random(seed);
            vb = $random(seed);
            aluSteps(datapathPkg::aluOpT'(op), va, vb);
        end

        for (int i = 0; i < 4; i++) begin
            row(LdZ, DrPc, PcInc, 32'd0, pcModel);
            pcModel++;
            row(LdPc, DrZLo, 4'b0, 32'd0, pcModel);
        end
        row(NoLd, DrPc, 4'b0, 32'd0, pcModel);

        va  = 32'h8765_4321;
        vb  = 32'hffff_ff10;
        res = aluRef(datapathPkg::OpMul, va, vb);
        aluSteps(datapathPkg::OpMul, va, vb);
        row(LdHi, DrZHi, 4'b0, 32'd0, res[63:32]);
        row(LdLo, DrZLo, 4'b0, 32'd0, res[31:0]);
        row(NoLd, DrHi, 4'b0, 32'd0, res[63:32]);
        row(NoLd, DrLo, 4'b0, 32'd0, res[31:0]);
        tableReady = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        foreach (steps[i]) begin
            load      = steps[i].load;
            drive     = steps[i].drive;
            mdrIn     = steps[i].mdrIn;
            read      = steps[i].read;
            inPortIn  = steps[i].inPortIn;
            incPc     = steps[i].incPc;
            opcode    = steps[i].opcode;
            memData   = steps[i].memData;
            inPort    = steps[i].inPort;
            constData = steps[i].constData;
            #8;  // just before the next edge
            if (steps[i].chkBus) checkWord(i, steps[i].expBus, busOut);
            if (steps[i].chkAddr) checkAddr(i, steps[i].expAddr, addrOut);
            @(posedge clk);
            #1;
        end

        $display("tbDatapath: %0d rows, %0d errors", steps.size(), errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               yIn,
    input  logic               zIn,
    input  logic               incPc,
    input  datapathPkg::aluOpT opcode,
    input  datapathPkg::wordT  bus,
    output datapathPkg::wordT  zHigh,
    output datapathPkg::wordT  zLow
);

    datapathPkg::wordT  y;
    datapathPkg::dwordT zReg;
    datapathPkg::dwordT result;
    logic [4:0]         shAmt;
    logic [63:0]        prod;
    datapathPkg::wordT  quot;
    datapathPkg::wordT  rem;

    // operand A
    always_ff @(posedge clk) begin
        if (!rstN) begin
            y <= '0;
        end else if (yIn) begin
            y <= bus;
        end
    end

    assign shAmt = bus[4:0];
    assign prod  = $signed({{32{y[31]}}, y}) * $signed({{32{bus[31]}}, bus});

    // divide by zero gives all zeros
    always_comb begin
        if (bus == '0) begin
            quot = '0;
            rem  = '0;
        end else begin
            quot = $signed(y) / $signed(bus);
            rem  = $signed(y) % $signed(bus);
        end
    end

    always_comb begin
        result = '0;
        if (incPc) begin
            result = {32'd0, bus + 32'd1};  // pc increment wins over opcode
        end else begin
            case (opcode)
                datapathPkg::OpAdd:  result = {32'd0, y + bus};
                datapathPkg::OpSub:  result = {32'd0, y - bus};
                datapathPkg::OpAnd:  result = {32'd0, y & bus};
                datapathPkg::OpOr:   result = {32'd0, y | bus};
                datapathPkg::OpShr:  result = {32'd0, y >> shAmt};
                datapathPkg::OpShra: result = {32'd0, $signed(y) >>> shAmt};
                datapathPkg::OpShl:  result = {32'd0, y << shAmt};
                datapathPkg::OpRor:  result = {32'd0, (y >> shAmt) | (y << (6'd32 - shAmt))};
                datapathPkg::OpRol:  result = {32'd0, (y << shAmt) | (y >> (6'd32 - shAmt))};
                datapathPkg::OpMul:  result = prod;
                datapathPkg::OpDiv:  result = {rem, quot};  // remainder high
                datapathPkg::OpNeg:  result = {32'd0, -bus};
                datapathPkg::OpNot:  result = {32'd0, ~bus};
                default:             result = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= result;
        end
    end

    assign zHigh = zReg[63:32];
    assign zLow  = zReg[31:0];

    // an undefined code would load zero into Z without notice
    assert property (@(posedge clk) disable iff (!rstN)
        zIn |-> (!$isunknown(opcode) && opcode <= datapathPkg::OpNot))
        else $error("aluUnit: undefined opcode %0d with zIn", opcode);

endmodule

/* verilog/busMux.sv */
`timescale 1ns/10ps

module busMux (
    input  logic                  clk,
    input  logic                  rstN,
    input  datapathPkg::driveStrbT drive,
    input  datapathPkg::regSrcT   regs,
    input  datapathPkg::wordT     zHigh,
    input  datapathPkg::wordT     zLow,
    input  datapathPkg::wordT     mdr,
    input  datapathPkg::wordT     inPortVal,
    input  datapathPkg::wordT     constData,
    output datapathPkg::wordT     bus
);

    logic [23:0]       srcReq;
    logic [4:0]        srcIdx;
    logic              srcValid;
    datapathPkg::wordT srcWord [24];

    // index 0..15 are the gprs, then the special sources
    assign srcReq = {drive.cOut, drive.inPortOut, drive.mdrOut, drive.pcOut,
                     drive.zLowOut, drive.zHighOut, drive.loOut, drive.hiOut,
                     drive.gprOut};

    // encoder, lowest index wins
    always_comb begin
        srcIdx   = '0;
        srcValid = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (srcReq[i]) begin
                srcIdx   = 5'(i);
                srcValid = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            srcWord[i] = regs.gpr[i];
        end
        srcWord[16] = regs.hi;
        srcWord[17] = regs.lo;
        srcWord[18] = zHigh;
        srcWord[19] = zLow;
        srcWord[20] = regs.pc;
        srcWord[21] = mdr;
        srcWord[22] = inPortVal;
        srcWord[23] = constData;
    end

    assign bus = srcValid ? srcWord[srcIdx] : '0;  // idle bus reads zero

    // a second driver would be silently dropped by the encoder
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(srcReq))
        else $error("busMux: more than one drive strobe high (%b)", srcReq);

endmodule

/* verilog/datapath.sv */
`timescale 1ns/10ps

module datapath (
    input  logic                   clk,
    input  logic                   rstN,
    input  datapathPkg::loadStrbT  load,
    input  datapathPkg::driveStrbT drive,
    input  logic                   mdrIn,
    input  logic                   read,
    input  logic                   inPortIn,
    input  logic                   incPc,
    input  datapathPkg::aluOpT     opcode,
    input  datapathPkg::wordT      memData,
    input  datapathPkg::wordT      inPort,
    input  datapathPkg::wordT      constData,
    output datapathPkg::wordT      busOut,
    output datapathPkg::wordT      addrOut
);

    datapathPkg::wordT   bus;
    datapathPkg::regSrcT regs;
    datapathPkg::wordT   mdr;
    datapathPkg::wordT   inPortVal;
    datapathPkg::wordT   zHigh;
    datapathPkg::wordT   zLow;

    regBank regBankI (
        .clk  (clk),
        .rstN (rstN),
        .load (load),
        .bus  (bus),
        .regs (regs)
    );

    memIoRegs memIoRegsI (
        .clk       (clk),
        .rstN      (rstN),
        .mdrIn     (mdrIn),
        .read      (read),
        .inPortIn  (inPortIn),
        .bus       (bus),
        .memData   (memData),
        .inPort    (inPort),
        .mdr       (mdr),
        .inPortVal (inPortVal)
    );

    busMux busMuxI (
        .clk       (clk),
        .rstN      (rstN),
        .drive     (drive),
        .regs      (regs),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .mdr       (mdr),
        .inPortVal (inPortVal),
        .constData (constData),
        .bus       (bus)
    );

    aluUnit aluUnitI (
        .clk    (clk),
        .rstN   (rstN),
        .yIn    (load.yIn),
        .zIn    (load.zIn),
        .incPc  (incPc),
        .opcode (opcode),
        .bus    (bus),
        .zHigh  (zHigh),
        .zLow   (zLow)
    );

    assign busOut  = bus;
    assign addrOut = regs.mar;  // memory address from MAR

endmodule

/* verilog/datapathPkg.sv */
package datapathPkg;

    typedef logic [31:0] wordT;
    typedef logic [63:0] dwordT;

    // encodings follow the listed order, 0 to 12
    typedef enum logic [4:0] {
        OpAdd  = 5'd0,
        OpSub  = 5'd1,
        OpAnd  = 5'd2,
        OpOr   = 5'd3,
        OpShr  = 5'd4,
        OpShra = 5'd5,
        OpShl  = 5'd6,
        OpRor  = 5'd7,
        OpRol  = 5'd8,
        OpMul  = 5'd9,
        OpDiv  = 5'd10,
        OpNeg  = 5'd11,
        OpNot  = 5'd12
    } aluOpT;

    typedef struct packed {
        logic [15:0] gprIn;  // one per R0..R15
        logic        hiIn;
        logic        loIn;
        logic        pcIn;
        logic        marIn;
        logic        yIn;
        logic        zIn;
    } loadStrbT;

    typedef struct packed {
        logic [15:0] gprOut;
        logic        hiOut;
        logic        loOut;
        logic        zHighOut;
        logic        zLowOut;
        logic        pcOut;
        logic        mdrOut;
        logic        inPortOut;
        logic        cOut;  // constant input onto the bus
    } driveStrbT;

    typedef struct packed {
        wordT [15:0] gpr;
        wordT        hi;
        wordT        lo;
        wordT        pc;
        wordT        mar;  // not a bus source, exposed as the address
    } regSrcT;

endpackage

/* verilog/memIoRegs.sv */
`timescale 1ns/10ps

module memIoRegs (
    input  logic              clk,
    input  logic              rstN,
    input  logic              mdrIn,
    input  logic              read,
    input  logic              inPortIn,
    input  datapathPkg::wordT bus,
    input  datapathPkg::wordT memData,
    input  datapathPkg::wordT inPort,
    output datapathPkg::wordT mdr,
    output datapathPkg::wordT inPortVal
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mdr       <= '0;
            inPortVal <= '0;
        end else begin
            if (mdrIn) begin
                mdr <= read ? memData : bus;  // read selects memory side
            end
            if (inPortIn) begin
                inPortVal <= inPort;
            end
        end
    end

endmodule

/* verilog/regBank.sv */
`timescale 1ns/10ps

module regBank (
    input  logic                  clk,
    input  logic                  rstN,
    input  datapathPkg::loadStrbT load,
    input  datapathPkg::wordT     bus,
    output datapathPkg::regSrcT   regs
);

    // R0 behaves like any other register here
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs.gpr[i] <= '0;
            end
            regs.hi  <= '0;
            regs.lo  <= '0;
            regs.pc  <= '0;
            regs.mar <= '0;
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (load.gprIn[i]) begin
                    regs.gpr[i] <= bus;
                end
            end
            if (load.hiIn) begin
                regs.hi <= bus;
            end
            if (load.loIn) begin
                regs.lo <= bus;
            end
            if (load.pcIn) begin
                regs.pc <= bus;  // incremented value comes back via zLow
            end
            if (load.marIn) begin
                regs.mar <= bus;
            end
        end
    end

    // address seen outside must not drift between loads
    assert property (@(posedge clk) (rstN && !load.marIn) |=> $stable(regs.mar))
        else $error("regBank: MAR changed without marIn");

endmodule
